//--- dv/uartTb.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uartTb import uartPkg::*; ();

    localparam busAddr addrBaud    = 13'h020;
    localparam busAddr addrTxData  = 13'h024;
    localparam busAddr addrRxData  = 13'h028;
    localparam busAddr addrStatus  = 13'h02C;
    localparam busAddr addrHole    = 13'h026;   // in the window, no register.
    localparam busAddr addrOutside = 13'h030;

    localparam busData txFullBit  = 32'h1;
    localparam busData txEmptyBit = 32'h2;
    localparam busData rxAvailBit = 32'h4;

    localparam int depth     = `UART_FIFO_DEPTH;
    localparam int fastDiv   = int'(`UART_RESET_DIV);
    localparam int slowDiv   = 15;
    localparam int fastFrame = 10 * 16 * (fastDiv + 1);
    localparam int slowFrame = 10 * 16 * (slowDiv + 1);
    // depth+2 frames at the reset divisor, depth+1 in the overflow run.
    localparam int watchdogCycles = (depth + 2) * fastFrame + (depth + 1) * slowFrame + 20000;

    logic        busClk;
    logic        reset;
    logic        cs;
    busAddr      addr;
    busData      dataIn;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    logic        rd;
    busData      dataOut;
    logic        txd;
    logic        rxd;
    logic        loopSel;
    logic        rxdBang;
    logic [15:0] lfsrState;
    string       testName;
    int          testErrors;
    int          testCount;
    int          testsFailed;
    int          errorCount;

    assign rxd = loopSel ? txd : rxdBang;   // loopback or bit-banged frame.

    uartTop uartTop_inst (
        .busClk  (busClk),
        .reset   (reset),
        .cs      (cs),
        .addr    (addr),
        .dataIn  (dataIn),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .wr3     (wr3),
        .rd      (rd),
        .dataOut (dataOut),
        .txd     (txd),
        .rxd     (rxd)
    );

    initial begin
        busClk = 1'b0;
        forever #2 busClk = ~busClk;
    end

    // ########################################################################
    // helpers
    // ########################################################################

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic nextRandomByte(output uartByte b);
        for (int i = 0; i < 8; i++) begin
            b[i]      = lfsrState[0];
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    task automatic busWrite(input busAddr a, input busData d, input logic [3:0] lanes);
        @(negedge busClk);
        cs     = 1'b1;
        addr   = a;
        dataIn = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(negedge busClk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    // a read of RX_DATA also pops the entry.
    task automatic busRead(input busAddr a, output busData d);
        @(negedge busClk);
        cs   = 1'b1;
        addr = a;
        rd   = 1'b1;
        #1;
        d = dataOut;
        @(negedge busClk);
        cs = 1'b0;
        rd = 1'b0;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        testCount++;
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            $display("test %s: %0d errors", testName, testErrors);
            testsFailed++;
            errorCount += testErrors;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%s: %s", testName, msg);
        testErrors++;
    endtask

    task automatic checkData(input string what, input busData expected, input busData actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h",
                     testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkByte(input string what, input uartByte expected, input uartByte actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected 0x%02h, actual 0x%02h",
                     testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic waitRxAvail(input int limitCycles, output bit seen);
        busData status;
        int     waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < limitCycles) begin
            busRead(addrStatus, status);
            seen = status[2];
            waited += 2;
        end
        if (!seen) reportProblem("received data did not show up in time");
    endtask

    task automatic waitTxIdle(input int limitCycles);
        busData status;
        int     waited;
        bit     idle;
        idle   = 1'b0;
        waited = 0;
        while (!idle && waited < limitCycles) begin
            busRead(addrStatus, status);
            idle = !status[3];
            waited += 2;
        end
        if (!idle) reportProblem("transmitter stayed busy too long");
    endtask

    task automatic waitStartBit(input int limitCycles);
        int waited;
        waited = 0;
        while (txd && waited < limitCycles) begin
            @(negedge busClk);
            waited++;
        end
        if (txd) reportProblem("no start bit on txd after the write");
    endtask

    task automatic popAndCompare(input uartByte expByte, input logic expErr,
                                 input string what, input int limitCycles);
        busData d;
        bit     seen;
        waitRxAvail(limitCycles, seen);
        if (seen) begin
            busRead(addrRxData, d);
            checkByte(what, expByte, d[7:0]);
            checkData({what, " entry"}, {23'h0, expErr, expByte}, d);
        end
    endtask

    task automatic driveFrame(input uartByte b, input logic stopLevel, input int bitCycles);
        @(negedge busClk);
        rxdBang = 1'b0;                 // start bit.
        repeat (bitCycles) @(negedge busClk);
        for (int i = 0; i < 8; i++) begin
            rxdBang = b[i];
            repeat (bitCycles) @(negedge busClk);
        end
        rxdBang = stopLevel;
        repeat (bitCycles) @(negedge busClk);
        rxdBang = 1'b1;
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################

    task automatic resetDefaults();
        busData d;
        startTest("resetDefaults");
        busRead(addrBaud, d);
        checkData("baud divisor", busData'(`UART_RESET_DIV), d);
        busRead(addrRxData, d);                 // pop attempt on an empty fifo.
        busRead(addrStatus, d);
        checkData("status", txEmptyBit, d);
        checkData("txd level", 32'h1, {31'h0, txd});
        finishTest();
    endtask

    task automatic baudByteLanes();
        busData d;
        startTest("baudByteLanes");
        busWrite(addrBaud, 32'hA5A5_01C3, 4'b0010);   // only bits 15:8 move.
        busRead(addrBaud, d);
        checkData("wr1 only", 32'h0000_0103, d);
        busWrite(addrBaud, 32'h7E7E_FFFF, 4'b1100);
        busRead(addrBaud, d);
        checkData("wr2 and wr3", 32'h0000_0103, d);
        busWrite(addrBaud, busData'(fastDiv), 4'b0011);
        busRead(addrBaud, d);
        checkData("restored divisor", busData'(fastDiv), d);
        busRead(addrHole, d);
        checkData("unmapped offset", 32'h0, d);
        busRead(addrOutside, d);
        checkData("outside window", 32'h0, d);
        busRead(addrTxData, d);
        checkData("tx data read", 32'h0, d);
        finishTest();
    endtask

    task automatic loopbackSingle();
        busData d;
        startTest("loopbackSingle");
        loopSel = 1'b1;
        busWrite(addrTxData, 32'h0000_00C4, 4'b0001);
        popAndCompare(8'hC4, 1'b0, "looped byte", 2 * fastFrame + 1024);
        busRead(addrStatus, d);
        checkData("rxAvail after pop", 32'h0, d & rxAvailBit);
        finishTest();
    endtask

    task automatic loopbackBurst();
        uartByte sent[$];
        uartByte b;
        busData  d;
        startTest("loopbackBurst");
        repeat (depth) begin
            nextRandomByte(b);
            sent.push_back(b);
            busWrite(addrTxData, {24'h0, b}, 4'b0001);
        end
        foreach (sent[i]) begin
            popAndCompare(sent[i], 1'b0, $sformatf("burst byte %0d", i), 2 * fastFrame);
        end
        busRead(addrStatus, d);
        checkData("rxAvail after burst", 32'h0, d & rxAvailBit);
        finishTest();
    endtask

    task automatic rxFramingError();
        uartByte b;
        busData  d;
        startTest("rxFramingError");
        nextRandomByte(b);
        loopSel = 1'b0;
        driveFrame(b, 1'b0, 16 * (fastDiv + 1));       // stop bit held low.
        popAndCompare(b, 1'b1, "bad frame", fastFrame);
        busRead(addrStatus, d);
        checkData("rxAvail after pop", 32'h0, d & rxAvailBit);
        loopSel = 1'b1;
        finishTest();
    endtask

    task automatic txOverflowDrop();
        uartByte sent[$];
        uartByte b;
        busData  d;
        startTest("txOverflowDrop");
        waitTxIdle(2 * fastFrame);
        busWrite(addrBaud, busData'(slowDiv), 4'b0011);
        nextRandomByte(b);
        sent.push_back(b);
        busWrite(addrTxData, {24'h0, b}, 4'b0001);
        // idle transmitter takes it at the next sample tick.
        waitStartBit(2 * (slowDiv + 1) + 4);
        repeat (depth + 2) begin
            nextRandomByte(b);
            sent.push_back(b);
            busWrite(addrTxData, {24'h0, b}, 4'b0001);
        end
        busRead(addrStatus, d);
        checkData("txFull", txFullBit, d & txFullBit);
        for (int i = 0; i < depth + 1; i++) begin
            popAndCompare(sent[i], 1'b0, $sformatf("kept byte %0d", i), 2 * slowFrame);
        end
        waitTxIdle(2 * slowFrame);
        busRead(addrStatus, d);
        checkData("dropped bytes absent", 32'h0, d & rxAvailBit);
        finishTest();
    endtask

    // ########################################################################
    // sequence and watchdog
    // ########################################################################

    initial begin
        reset       = 1'b1;
        cs          = 1'b0;
        addr        = '0;
        dataIn      = '0;
        wr0         = 1'b0;
        wr1         = 1'b0;
        wr2         = 1'b0;
        wr3         = 1'b0;
        rd          = 1'b0;
        loopSel     = 1'b1;
        rxdBang     = 1'b1;
        lfsrState   = 16'd46885;
        testCount   = 0;
        testsFailed = 0;
        errorCount  = 0;
        repeat (8) @(posedge busClk);
        @(negedge busClk);
        reset = 1'b0;

        resetDefaults();
        baudByteLanes();
        loopbackSingle();
        loopbackBurst();
        rxFramingError();
        txOverflowDrop();

        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 testCount, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge busClk);
        $display("watchdog: run did not finish within %0d cycles", watchdogCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- dv/uartTop_sva.sv
`timescale 1ns/100ps

module uartTopSva (
    input logic        busClk,
    input logic        reset,
    input logic        txd,
    input logic        txBusy,
    input logic        sampleEn,
    input logic [15:0] baudDiv,
    input logic        txPushValid,
    input logic        txPopValid,
    input logic        rxPushValid,
    input logic        rxPopValid
);

    // ########################################################################
    // serial line
    // ########################################################################

    idleLineHigh: assert property (@(posedge busClk) disable iff (reset)
        !txBusy |-> txd)
        else $error("txd low while the transmitter is idle");

    // ########################################################################
    // handshakes and tick
    // ########################################################################

    // an empty fifo with nothing pushed stays empty.
    txPopNeedsData: assert property (@(posedge busClk) disable iff (reset)
        (!txPopValid && !txPushValid) |=> !txPopValid)
        else $error("tx fifo popped while empty");

    rxPopNeedsData: assert property (@(posedge busClk) disable iff (reset)
        (!rxPopValid && !rxPushValid) |=> !rxPopValid)
        else $error("rx fifo popped while empty");

    tickIsPulse: assert property (@(posedge busClk) disable iff (reset)
        (sampleEn && baudDiv != 16'h0) |=> !sampleEn)
        else $error("sampleEn high on two cycles in a row");

endmodule

bind uartTop uartTopSva uartTopSva_inst (
    .busClk      (busClk),
    .reset       (reset),
    .txd         (txd),
    .txBusy      (txBusy),
    .sampleEn    (sampleEn),
    .baudDiv     (baudDiv),
    .txPushValid (txPushValid),
    .txPopValid  (txPopValid),
    .rxPushValid (rxPushValid),
    .rxPopValid  (rxPopValid)
);

//--- hw/uartBaudGen.sv
`timescale 1ns/100ps

module uartBaudGen (
    input  logic        busClk,
    input  logic        reset,
    input  logic [15:0] baudDiv,
    output logic        sampleEn
);

    logic [15:0] baudCount;

    // one tick every baudDiv+1 cycles, 16 ticks per bit.
    always_ff @(posedge busClk) begin
        if (reset) begin
            baudCount <= baudDiv;
            sampleEn  <= 1'b0;
        end else if (baudCount == 16'h0) begin
            baudCount <= baudDiv;   // reload.
            sampleEn  <= 1'b1;
        end else begin
            baudCount <= baudCount - 1'b1;
            sampleEn  <= 1'b0;
        end
    end

endmodule

//--- hw/uartFifo.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uartFifo import uartPkg::*; #(
    parameter type entryType = uartByte,
    parameter int  depth     = `UART_FIFO_DEPTH
) (
    input  logic     busClk,
    input  logic     reset,
    input  logic     pushValid,
    input  entryType pushData,
    output logic     pushReady,
    output logic     popValid,
    output entryType popData,
    input  logic     popReady
);

    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;

    entryType           mem [depth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits:0]   count;
    logic               doPush;
    logic               doPop;

    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        if (ptr == ptrBits'(depth - 1)) return '0;
        return ptr + 1'b1;
    endfunction

    assign pushReady = (count != (ptrBits + 1)'(depth));
    assign popValid  = (count != '0);
    assign popData   = mem[rdPtr];

    assign doPush = pushValid & pushReady;
    assign doPop  = popValid & popReady;

    always_ff @(posedge busClk) begin
        if (doPush) mem[wrPtr] <= pushData;
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither, level unchanged.
            endcase
        end
    end

endmodule

//--- hw/uartPkg.sv
package uartPkg;

    // ########################################################################
    // bus side
    // ########################################################################

    typedef logic [12:0] busAddr;
    typedef logic [31:0] busData;

    // ########################################################################
    // serial side
    // ########################################################################

    typedef logic [7:0] uartByte;

    // one received character as it sits in the rx fifo.
    typedef struct packed {
        logic    frameErr;  // stop bit sampled low.
        uartByte data;
    } rxEntry;

endpackage

//--- hw/uartRegs.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uartRegs import uartPkg::*; (
    input  logic        busClk,
    input  logic        reset,
    input  logic        cs,
    input  busAddr      addr,
    input  busData      dataIn,
    input  logic        wr0,
    input  logic        wr1,
    input  logic        wr2,
    input  logic        wr3,
    input  logic        rd,
    output busData      dataOut,
    output logic        txPushValid,
    output uartByte     txPushData,
    input  logic        txPushReady,
    input  logic        rxPopValid,
    input  rxEntry      rxPopData,
    output logic        rxPopReady,
    input  logic        txBusy,
    output logic [15:0] baudDiv
);

    logic uartSpace;
    logic selBaud;
    logic selTxData;
    logic selRxData;
    logic selStatus;
    logic wrAny;
    logic txFull;
    logic txEmpty;
    logic rxAvail;

    always_comb begin
        casex (addr)
            `UARTSPACE: uartSpace = cs;
            default:    uartSpace = 1'b0;
        endcase
    end

    always_comb begin
        selBaud   = 1'b0;
        selTxData = 1'b0;
        selRxData = 1'b0;
        selStatus = 1'b0;
        if (uartSpace) begin
            casex (addr)
                `UART_BAUD_DIV: selBaud   = 1'b1;
                `UART_TX_DATA:  selTxData = 1'b1;
                `UART_RX_DATA:  selRxData = 1'b1;
                `UART_STATUS:   selStatus = 1'b1;
                default:        ;
            endcase
        end
    end

    // a cycle carrying any write lane is not a read.
    assign wrAny = wr0 | wr1 | wr2 | wr3;

    // divisor, only the two low lanes exist.
    always_ff @(posedge busClk) begin
        if (reset) begin
            baudDiv <= `UART_RESET_DIV;
        end else if (selBaud) begin
            if (wr0) baudDiv[7:0] <= dataIn[7:0];
            if (wr1) baudDiv[15:8] <= dataIn[15:8];
        end
    end

    assign txPushValid = selTxData & wr0;     // dropped by the fifo when full.
    assign txPushData  = dataIn[7:0];
    assign rxPopReady  = selRxData & rd & ~wrAny & rxPopValid;

    assign txFull  = ~txPushReady;
    assign txEmpty = ~txBusy;                 // fifo drained and shifter idle.
    assign rxAvail = rxPopValid;

    always_comb begin
        dataOut = '0;
        if (selBaud) begin
            dataOut = {16'h0, baudDiv};
        end else if (selRxData && rxPopValid) begin
            dataOut = {23'h0, rxPopData};
        end else if (selStatus) begin
            dataOut = {28'h0, txBusy, rxAvail, txEmpty, txFull};
        end
    end

endmodule

//--- hw/uartRx.sv
`timescale 1ns/100ps

module uartRx import uartPkg::*; (
    input  logic   busClk,
    input  logic   reset,
    input  logic   sampleEn,
    input  logic   rxd,
    output logic   pushValid,
    output rxEntry pushData,
    input  logic   pushReady
);

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stData,
        stStop
    } rxStateT;

    rxStateT    state;
    logic       rxdMeta;
    logic       rxdSync;
    logic       rxdPrev;
    logic       startFall;
    uartByte    shiftReg;
    logic [2:0] bitCnt;
    logic [3:0] tickCnt;

    // ########################################################################
    // input synchronizer and edge detect
    // ########################################################################

    always_ff @(posedge busClk) begin
        if (reset) begin
            rxdMeta <= 1'b1;
            rxdSync <= 1'b1;
            rxdPrev <= 1'b1;
        end else begin
            rxdMeta <= rxd;
            rxdSync <= rxdMeta;
            rxdPrev <= rxdSync;
        end
    end

    assign startFall = rxdPrev & ~rxdSync;

    // ########################################################################
    // frame recovery
    // ########################################################################

    always_ff @(posedge busClk) begin
        if (reset) begin
            state     <= stIdle;
            bitCnt    <= 3'd0;
            tickCnt   <= 4'd0;
            pushValid <= 1'b0;
        end else begin
            // no stall, an entry not taken by the next tick is lost.
            if (pushReady || sampleEn) pushValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (startFall) begin
                        state   <= stStart;
                        tickCnt <= 4'd0;
                    end
                end
                stStart: begin
                    if (sampleEn) begin
                        tickCnt <= tickCnt + 1'b1;
                        if (tickCnt == 4'd7) begin
                            if (rxdSync) begin
                                state <= stIdle;    // glitch, not a start bit.
                            end else begin
                                state   <= stData;
                                tickCnt <= 4'd0;
                                bitCnt  <= 3'd0;
                            end
                        end
                    end
                end
                stData: begin
                    if (sampleEn) begin
                        tickCnt <= tickCnt + 1'b1;
                        if (tickCnt == 4'd15) begin
                            shiftReg <= {rxdSync, shiftReg[7:1]};
                            bitCnt   <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) state <= stStop;
                        end
                    end
                end
                default: begin
                    if (sampleEn) begin
                        tickCnt <= tickCnt + 1'b1;
                        if (tickCnt == 4'd15) begin
                            state             <= stIdle;
                            pushValid         <= 1'b1;
                            pushData.data     <= shiftReg;
                            pushData.frameErr <= ~rxdSync;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/uartTop.sv
`timescale 1ns/100ps

module uartTop import uartPkg::*; (
    input  logic   busClk,
    input  logic   reset,
    input  logic   cs,
    input  busAddr addr,
    input  busData dataIn,
    input  logic   wr0,
    input  logic   wr1,
    input  logic   wr2,
    input  logic   wr3,
    input  logic   rd,
    output busData dataOut,
    output logic   txd,
    input  logic   rxd
);

    logic [15:0] baudDiv;
    logic        sampleEn;
    logic        txBusy;

    // transmit path.
    logic        txPushValid;
    uartByte     txPushData;
    logic        txPushReady;
    logic        txPopValid;
    uartByte     txPopData;
    logic        txPopReady;

    // receive path.
    logic        rxPushValid;
    rxEntry      rxPushData;
    logic        rxPushReady;
    logic        rxPopValid;
    rxEntry      rxPopData;
    logic        rxPopReady;

    uartRegs uartRegs_inst (
        .busClk      (busClk),
        .reset       (reset),
        .cs          (cs),
        .addr        (addr),
        .dataIn      (dataIn),
        .wr0         (wr0),
        .wr1         (wr1),
        .wr2         (wr2),
        .wr3         (wr3),
        .rd          (rd),
        .dataOut     (dataOut),
        .txPushValid (txPushValid),
        .txPushData  (txPushData),
        .txPushReady (txPushReady),
        .rxPopValid  (rxPopValid),
        .rxPopData   (rxPopData),
        .rxPopReady  (rxPopReady),
        .txBusy      (txBusy),
        .baudDiv     (baudDiv)
    );

    uartBaudGen uartBaudGen_inst (
        .busClk   (busClk),
        .reset    (reset),
        .baudDiv  (baudDiv),
        .sampleEn (sampleEn)
    );

    uartFifo #(.entryType(uartByte)) txFifo_inst (
        .busClk    (busClk),
        .reset     (reset),
        .pushValid (txPushValid),
        .pushData  (txPushData),
        .pushReady (txPushReady),
        .popValid  (txPopValid),
        .popData   (txPopData),
        .popReady  (txPopReady)
    );

    uartFifo #(.entryType(rxEntry)) rxFifo_inst (
        .busClk    (busClk),
        .reset     (reset),
        .pushValid (rxPushValid),
        .pushData  (rxPushData),
        .pushReady (rxPushReady),
        .popValid  (rxPopValid),
        .popData   (rxPopData),
        .popReady  (rxPopReady)
    );

    uartTx uartTx_inst (
        .busClk   (busClk),
        .reset    (reset),
        .sampleEn (sampleEn),
        .popValid (txPopValid),
        .popData  (txPopData),
        .popReady (txPopReady),
        .txBusy   (txBusy),
        .txd      (txd)
    );

    uartRx uartRx_inst (
        .busClk    (busClk),
        .reset     (reset),
        .sampleEn  (sampleEn),
        .rxd       (rxd),
        .pushValid (rxPushValid),
        .pushData  (rxPushData),
        .pushReady (rxPushReady)
    );

endmodule

//--- hw/uartTx.sv
`timescale 1ns/100ps

module uartTx import uartPkg::*; (
    input  logic    busClk,
    input  logic    reset,
    input  logic    sampleEn,
    input  logic    popValid,
    input  uartByte popData,
    output logic    popReady,
    output logic    txBusy,
    output logic    txd
);

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stData,
        stStop
    } txStateT;

    txStateT    state;
    uartByte    shiftReg;
    logic [2:0] bitCnt;
    logic [3:0] tickCnt;
    logic       bitEnd;
    logic       take;

    assign bitEnd   = sampleEn & (tickCnt == 4'd15);
    assign popReady = sampleEn & ((state == stIdle) | ((state == stStop) & (tickCnt == 4'd15)));
    assign take     = popValid & popReady;

    // pending fifo data counts as busy.
    assign txBusy = (state != stIdle) | popValid;

    always_ff @(posedge busClk) begin
        if (reset) begin
            state   <= stIdle;
            txd     <= 1'b1;
            bitCnt  <= 3'd0;
            tickCnt <= 4'd0;
        end else if (take) begin
            // new frame, also chains straight out of a stop bit.
            state    <= stStart;
            shiftReg <= popData;
            txd      <= 1'b0;
            tickCnt  <= 4'd0;
        end else if (sampleEn && state != stIdle) begin
            tickCnt <= tickCnt + 1'b1;
            if (bitEnd) begin
                case (state)
                    stStart: begin
                        state    <= stData;
                        txd      <= shiftReg[0];    // lsb first.
                        shiftReg <= {1'b0, shiftReg[7:1]};
                        bitCnt   <= 3'd0;
                    end
                    stData: begin
                        if (bitCnt == 3'd7) begin
                            state <= stStop;
                            txd   <= 1'b1;
                        end else begin
                            txd      <= shiftReg[0];
                            shiftReg <= {1'b0, shiftReg[7:1]};
                            bitCnt   <= bitCnt + 1'b1;
                        end
                    end
                    default: state <= stIdle;       // stop done, nothing waiting.
                endcase
            end
        end
    end

endmodule

//--- hw/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// ###########################################################################
// address map
// ###########################################################################

// uart window at 0x020, low nibble selects the register.
`define UARTSPACE           13'b0_0000_0010_xxxx

// register offsets inside the window.
`define UART_BAUD_DIV       13'bx_xxxx_xxxx_0000
`define UART_TX_DATA        13'bx_xxxx_xxxx_0100
`define UART_RX_DATA        13'bx_xxxx_xxxx_1000
`define UART_STATUS         13'bx_xxxx_xxxx_1100

// ###########################################################################
// reset values and sizes
// ###########################################################################

`define UART_RESET_DIV      16'd3
`define UART_FIFO_DEPTH     8   // entries per fifo.

`endif

//--- project.f
+incdir+hw
hw/uartPkg.sv
hw/uartRegs.sv
hw/uartFifo.sv
hw/uartBaudGen.sv
hw/uartTx.sv
hw/uartRx.sv
hw/uartTop.sv
dv/uartTop_sva.sv
dv/uartTb.sv

//--- run.sh
#!/bin/sh
# builds the uart testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module uartTb -f project.f -o uartSim

./obj_dir/uartSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi
